//--- hw/iq_pkg.sv
// Instruction queue package
// Sizes of the line ring and decode window, plus the pointer and window
// types shared by the fetch side, the head control and the aligner

package iq_pkg;

   // Ring geometry
   localparam int IQ_ENTRIES    = 4;
   localparam int IQ_LINE_BYTES = 16;
   localparam int IQ_WIN_BYTES  = 32;
   localparam int IQ_RING_BYTES = IQ_ENTRIES * IQ_LINE_BYTES;

   // Byte count 0..64 needs 7 bits
   localparam int IQ_CNT_W = 7;

   // Pointer field widths
   localparam int IQ_IDX_W = $clog2(IQ_ENTRIES);
   localparam int IQ_OFF_W = $clog2(IQ_LINE_BYTES);

   // One fetched line, byte 0 in bits [7:0]
   typedef logic [IQ_LINE_BYTES*8-1:0] iq_line_t;

   // Write pointer, counts whole lines
   typedef struct packed {
      logic                wrap;
      logic [IQ_IDX_W-1:0] idx;
   } iq_tail_t;

   // Read pointer, counts bytes
   // Without the wrap bit this is a byte address in the ring
   typedef struct packed {
      logic                wrap;
      logic [IQ_IDX_W-1:0] idx;
      logic [IQ_OFF_W-1:0] off;
   } iq_head_t;

   // What the decoder sees
   typedef struct packed {
      logic [IQ_WIN_BYTES*8-1:0] data;
      logic [IQ_CNT_W-1:0]       valid_bytes;
   } iq_window_t;

endpackage

//--- hw/iq_entry_store.sv
// Instruction queue entry store
// Holds the four fetched lines with their valid bits and the tail pointer,
// and accepts new lines from the fetch side

`timescale 1ns/10ps

module iq_entry_store (
   input  logic                                      clk_i,
   input  logic                                      arst_n_i,
   input  logic                                      flush_i,
   // Fetch side
   input  logic                                      valid_i,
   input  iq_pkg::iq_line_t                          line_i,
   output logic                                      ready_o,
   // From head control
   input  logic [iq_pkg::IQ_ENTRIES-1:0]             release_i,
   // Ring state
   output iq_pkg::iq_tail_t                          tail_o,
   output iq_pkg::iq_line_t [iq_pkg::IQ_ENTRIES-1:0] entries_o
);

   import iq_pkg::*;

   iq_line_t [IQ_ENTRIES-1:0] entries_q;
   logic [IQ_ENTRIES-1:0]     valid_q;
   logic [IQ_ENTRIES-1:0]     set_vec;
   iq_tail_t                  tail_q;
   iq_tail_t                  tail_next;
   logic                      take;

   // No room while every entry is valid, and nothing enters during flush
   assign ready_o = ~((&valid_q) | flush_i);
   assign take    = valid_i & ready_o;

   assign tail_next = iq_tail_t'(tail_q + 3'd1);

   // One-hot write select at the tail
   always_comb begin
      set_vec = '0;
      if (take) begin
         set_vec[tail_q.idx] = 1'b1;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= '0;
         tail_q  <= '0;
      end else if (flush_i) begin
         valid_q <= '0;
         tail_q  <= '0;
      end else begin
         // Release first so a set on the same edge wins
         valid_q <= (valid_q & ~release_i) | set_vec;
         if (take) begin
            tail_q <= tail_next;
         end
      end
   end

   // Line payload, written only when accepted
   always_ff @(posedge clk_i) begin
      if (take) begin
         entries_q[tail_q.idx] <= line_i;
      end
   end

   assign tail_o    = tail_q;
   assign entries_o = entries_q;

endmodule

//--- hw/iq_head_ctrl.sv
// Instruction queue head control
// Tracks the decode byte pointer, derives the valid byte count from the
// tail, handles redirect loads and strobes entries free as the head leaves

`timescale 1ns/10ps

module iq_head_ctrl (
   input  logic                          clk_i,
   input  logic                          arst_n_i,
   input  logic                          flush_i,
   input  logic                          load_i,
   input  logic [3:0]                    load_address_i,
   // Decode side
   input  logic                          ready_i,
   input  logic [3:0]                    bytes_read_i,
   output logic                          valid_o,
   output logic [iq_pkg::IQ_CNT_W-1:0]   valid_bytes_o,
   // Ring state
   input  iq_pkg::iq_tail_t              tail_i,
   output iq_pkg::iq_head_t              head_o,
   output logic [iq_pkg::IQ_ENTRIES-1:0] release_o
);

   import iq_pkg::*;

   iq_head_t            head_q;
   iq_head_t            head_adv;
   iq_head_t            head_load;
   logic                consume;
   logic [IQ_CNT_W-1:0] tail_bytes;
   logic [IQ_CNT_W-1:0] diff;

   // Tail as a byte address including its wrap bit
   assign tail_bytes = (tail_i.wrap ? IQ_CNT_W'(IQ_RING_BYTES) : '0)
                     + IQ_CNT_W'(tail_i.idx) * IQ_CNT_W'(IQ_LINE_BYTES);

   assign diff = tail_bytes - IQ_CNT_W'(head_q);

   // After a redirect the head sits ahead of an empty tail; the wrapped
   // difference then lands above the ring size and means nothing is there
   assign valid_bytes_o = (diff > IQ_CNT_W'(IQ_RING_BYTES)) ? '0 : diff;
   assign valid_o       = |valid_bytes_o;

   assign consume  = valid_o & ready_i;
   assign head_adv = iq_head_t'(IQ_CNT_W'(head_q) + IQ_CNT_W'(bytes_read_i));

   // Redirect target is always entry 0 on the current lap
   always_comb begin
      head_load      = '0;
      head_load.off  = load_i ? load_address_i : '0;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         head_q <= '0;
      end else if (flush_i || load_i) begin
         head_q <= head_load;
      end else if (consume) begin
         head_q <= head_adv;
      end
   end

   // A consume of at most 15 bytes crosses at most one boundary
   always_comb begin
      release_o = '0;
      if (consume && !flush_i && !load_i && (head_adv.idx != head_q.idx)) begin
         release_o[head_q.idx] = 1'b1;
      end
   end

   assign head_o = head_q;

endmodule

//--- hw/iq_byte_aligner.sv
// Instruction queue byte aligner
// Joins the head entry with the one after it and shifts the pair so the
// decode window starts at the head byte

`timescale 1ns/10ps

module iq_byte_aligner (
   input  iq_pkg::iq_line_t [iq_pkg::IQ_ENTRIES-1:0] entries_i,
   input  iq_pkg::iq_head_t                          head_i,
   output logic [iq_pkg::IQ_WIN_BYTES*8-1:0]         window_o
);

   import iq_pkg::*;

   logic [IQ_IDX_W-1:0]       idx_next;
   logic [IQ_WIN_BYTES*8-1:0] pair;

   // Index wraps from entry 3 back to entry 0
   assign idx_next = head_i.idx + 1'b1;

   // Head entry in the low half
   assign pair = {entries_i[idx_next], entries_i[head_i.idx]};

   // Whole-byte right shift, zeros come in from the top
   assign window_o = pair >> {head_i.off, 3'b000};

endmodule

//--- hw/instruction_queue.sv
// Instruction queue top level
// Four-line ring between fetch and the length decoder, presenting a
// 32-byte window aligned to the current decode byte

`timescale 1ns/10ps

module instruction_queue (
   input  logic               clk_i,
   input  logic               arst_n_i,
   // Redirect
   input  logic               flush_i,
   input  logic               load_i,
   input  logic [3:0]         load_address_i,
   // Fetch side
   input  logic               valid_i,
   output logic               ready_o,
   input  iq_pkg::iq_line_t   line_i,
   // Decode side
   output logic               valid_o,
   input  logic               ready_i,
   input  logic [3:0]         bytes_read_i,
   output iq_pkg::iq_window_t window_o
);

   import iq_pkg::*;

   iq_tail_t                  tail;
   iq_head_t                  head;
   iq_line_t [IQ_ENTRIES-1:0] entries;
   logic [IQ_ENTRIES-1:0]     release_vec;
   logic [IQ_WIN_BYTES*8-1:0] window_data;
   logic [IQ_CNT_W-1:0]       valid_bytes;

   iq_entry_store u_entry_store (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .flush_i   (flush_i),
      .valid_i   (valid_i),
      .line_i    (line_i),
      .ready_o   (ready_o),
      .release_i (release_vec),
      .tail_o    (tail),
      .entries_o (entries)
   );

   iq_head_ctrl u_head_ctrl (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .flush_i        (flush_i),
      .load_i         (load_i),
      .load_address_i (load_address_i),
      .ready_i        (ready_i),
      .bytes_read_i   (bytes_read_i),
      .valid_o        (valid_o),
      .valid_bytes_o  (valid_bytes),
      .tail_i         (tail),
      .head_o         (head),
      .release_o      (release_vec)
   );

   iq_byte_aligner u_byte_aligner (
      .entries_i (entries),
      .head_i    (head),
      .window_o  (window_data)
   );

   assign window_o = '{data: window_data, valid_bytes: valid_bytes};

endmodule

//--- dv/instruction_queue_checker.sv
// Instruction queue assertion checker
// Bound into the top level to watch the count range, occupancy and flush

`timescale 1ns/10ps

module instruction_queue_checker (
   input logic                          clk_i,
   input logic                          arst_n_i,
   input logic                          flush_i,
   input logic                          valid_i,
   input logic                          fetch_ready_i,
   input logic                          dec_valid_i,
   input logic [iq_pkg::IQ_CNT_W-1:0]   valid_bytes_i,
   input logic [iq_pkg::IQ_ENTRIES-1:0] entry_valid_i
);

   import iq_pkg::*;

   // Never more bytes than the valid entries hold, so never above the ring size
   count_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      valid_bytes_i <= IQ_CNT_W'(IQ_LINE_BYTES * $countones(entry_valid_i)))
      else $error("valid byte count above what the valid entries hold");

   // More than three lines of unread bytes means all four entries are in use
   full_blocks_fetch: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (valid_bytes_i > IQ_CNT_W'(3 * IQ_LINE_BYTES)) |-> !fetch_ready_i)
      else $error("ready_o high with all four entries in use");

   // A flushed queue shows nothing on the next cycle
   flush_empties: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (flush_i && !(valid_i && fetch_ready_i)) |=> !dec_valid_i)
      else $error("valid_o high on the cycle after a flush");

   reset_empty: assert property (@(posedge clk_i)
      $rose(arst_n_i) |-> !dec_valid_i)
      else $error("valid_o high right after reset");

endmodule

//--- dv/instruction_queue_tb.sv
// Instruction queue testbench
// Runs a table of fetch, consume and redirect steps against a byte-level
// reference ring and checks the count, the window and ready_o

`timescale 1ns/10ps

module instruction_queue_tb;

   import iq_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 3;
   localparam int WD_MARGIN    = 20;

   typedef struct {
      string name;
      bit    offer;
      int    consume;
      bit    rdy;
      bit    redirect;
      int    offset;
      int    exp_cnt;   // -1 when the row has no fixed count
   } row_t;

   logic        clk;
   logic        arst_n;
   logic        flush;
   logic        load;
   logic [3:0]  load_address;
   logic        fetch_valid;
   logic        fetch_ready;
   iq_line_t    line;
   logic        dec_valid;
   logic        dec_ready;
   logic [3:0]  bytes_read;
   iq_window_t  window;

   row_t        rows[$];
   bit          table_built = 1'b0;
   logic [31:0] lfsr = 32'h0015_5d6a;
   int          err_count = 0;

   // Reference ring, one entry per byte still to be decoded
   logic [7:0]  ref_bytes[$];
   int          line_left[$];
   int          skip = 0;
   int          head_off = 0;
   bit          line_pending = 1'b0;
   iq_line_t    pend_line = '0;

   instruction_queue u_instruction_queue (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .flush_i        (flush),
      .load_i         (load),
      .load_address_i (load_address),
      .valid_i        (fetch_valid),
      .ready_o        (fetch_ready),
      .line_i         (line),
      .valid_o        (dec_valid),
      .ready_i        (dec_ready),
      .bytes_read_i   (bytes_read),
      .window_o       (window)
   );

   bind instruction_queue instruction_queue_checker u_checker (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .flush_i       (flush_i),
      .valid_i       (valid_i),
      .fetch_ready_i (ready_o),
      .dec_valid_i   (valid_o),
      .valid_bytes_i (valid_bytes),
      .entry_valid_i (u_entry_store.valid_q)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic next_line(output iq_line_t l);
      for (int b = 0; b < IQ_LINE_BYTES * 8; b++) begin
         lfsr = lfsr_next(lfsr);
         l[b] = lfsr[0];
      end
   endtask

   task automatic add_row(input string name, input bit offer, input int consume,
                          input bit rdy, input bit redirect, input int offset,
                          input int exp_cnt);
      row_t r;
      r = '{name, offer, consume, rdy, redirect, offset, exp_cnt};
      rows.push_back(r);
   endtask

   task automatic build_table();
      //           name          offer  n  rdy redir off  count
      add_row("reset_fill",   1,  0, 0, 0,  0, 16);
      add_row("reset_fill",   1,  0, 0, 0,  0, 32);
      add_row("reset_fill",   1,  0, 0, 0,  0, 48);
      add_row("reset_fill",   1,  0, 0, 0,  0, 64);
      add_row("full_stall",   1,  0, 0, 0,  0, 64);
      add_row("full_stall",   1, 10, 1, 0,  0, 54);
      add_row("full_stall",   1,  6, 1, 0,  0, 48);
      add_row("full_stall",   1,  0, 1, 0,  0, 64);
      add_row("consume_mix",  0, 15, 1, 0,  0, -1);
      add_row("consume_mix",  0, 13, 1, 0,  0, -1);
      add_row("consume_mix",  0,  0, 1, 0,  0, -1);
      add_row("consume_mix",  1,  7, 1, 0,  0, -1);
      add_row("consume_mix",  1,  9, 1, 0,  0, -1);
      add_row("consume_mix",  1, 15, 1, 0,  0, -1);
      add_row("consume_mix",  1, 11, 1, 0,  0, -1);
      add_row("consume_mix",  0,  3, 1, 0,  0, -1);
      add_row("consume_mix",  1, 14, 1, 0,  0, -1);
      add_row("consume_mix",  0,  1, 1, 0,  0, -1);
      add_row("consume_mix",  1,  8, 1, 0,  0, -1);
      add_row("consume_mix",  1, 12, 1, 0,  0, -1);
      add_row("consume_mix",  0, 15, 1, 0,  0, -1);
      add_row("hold",         0, 12, 0, 0,  0, -1);
      add_row("hold",         0,  5, 0, 0,  0, -1);
      add_row("hold",         0,  2, 1, 0,  0, -1);
      add_row("redirect",     0,  3, 1, 1,  5,  0);
      add_row("redirect",     1,  0, 1, 0,  0, 11);
      add_row("redirect",     1,  4, 1, 0,  0, 23);
      add_row("redirect",     0,  0, 1, 1, 15,  0);
      add_row("redirect",     1,  0, 1, 0,  0,  1);
      add_row("redirect",     1,  1, 1, 0,  0, 16);
      add_row("flush_drop",   1,  0, 1, 1,  2,  0);
      add_row("flush_drop",   0,  0, 1, 0,  0,  0);
      add_row("flush_drop",   1,  0, 1, 0,  0, 14);
      add_row("flush_drop",   0, 14, 1, 0,  0,  0);
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         err_count++;
         $display("mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
      end
   endtask

   task automatic push_line(input iq_line_t l);
      for (int b = skip; b < IQ_LINE_BYTES; b++) begin
         ref_bytes.push_back(l[8*b +: 8]);
      end
      line_left.push_back(IQ_LINE_BYTES - skip);
      skip = 0;
   endtask

   // Model step for the edge that applies one row
   task automatic update_ref(input row_t row, input int n, input bit take);
      if (row.redirect) begin
         ref_bytes.delete();
         line_left.delete();
         skip         = row.offset;
         head_off     = row.offset;
         line_pending = 1'b0;
      end else begin
         if (row.rdy && ref_bytes.size() > 0) begin
            for (int k = 0; k < n; k++) begin
               void'(ref_bytes.pop_front());
               line_left[0]--;
               if (line_left[0] == 0) begin
                  void'(line_left.pop_front());
               end
            end
            head_off = (head_off + n) % IQ_LINE_BYTES;
         end
         if (take) begin
            push_line(pend_line);
            line_pending = 1'b0;
         end
      end
   endtask

   task automatic check_outputs(input string test);
      int lim;
      check_value(test, "valid_bytes", 32'(ref_bytes.size()), 32'(window.valid_bytes));
      check_value(test, "valid_o", 32'(ref_bytes.size() > 0), 32'(dec_valid));
      // The shifted pair runs out above 32 minus the head offset
      lim = IQ_WIN_BYTES - head_off;
      if (ref_bytes.size() < lim) begin
         lim = ref_bytes.size();
      end
      for (int i = 0; i < lim; i++) begin
         check_value(test, $sformatf("window byte %0d", i), 32'(ref_bytes[i]),
                     32'(window.data[8*i +: 8]));
      end
   endtask

   initial begin : main
      row_t  row;
      int    n;
      bit    exp_ready;
      bit    take;
      int    grp_start;
      int    n_tests;
      int    n_failed;
      string name;

      grp_start = 0;
      n_tests   = 0;
      n_failed  = 0;
      build_table();
      table_built = 1'b1;

      arst_n       = 1'b0;
      flush        = 1'b0;
      load         = 1'b0;
      load_address = '0;
      fetch_valid  = 1'b0;
      line         = '0;
      dec_ready    = 1'b0;
      bytes_read   = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;

      for (int r = 0; r <= rows.size(); r++) begin
         @(posedge clk);
         n = 0;
         if (r < rows.size()) begin
            row = rows[r];
            if (!line_pending && row.offer) begin
               next_line(pend_line);
               line_pending = 1'b1;
            end
            n = (row.consume < ref_bytes.size()) ? row.consume : ref_bytes.size();
            fetch_valid  <= line_pending;
            line         <= pend_line;
            dec_ready    <= row.rdy;
            bytes_read   <= 4'(n);
            flush        <= row.redirect;
            load         <= row.redirect;
            load_address <= 4'(row.offset);
         end else begin
            fetch_valid <= 1'b0;
            dec_ready   <= 1'b0;
            bytes_read  <= '0;
            flush       <= 1'b0;
            load        <= 1'b0;
         end

         @(negedge clk);
         // Count and window show the result of the previous row
         name = (r == 0) ? rows[0].name : rows[r - 1].name;
         check_outputs(name);
         if (r > 0 && rows[r - 1].exp_cnt >= 0) begin
            check_value(name, "table count", 32'(rows[r - 1].exp_cnt),
                        32'(window.valid_bytes));
         end
         if (r > 0 && (r == rows.size() || rows[r].name != name)) begin
            n_tests++;
            if (err_count != grp_start) begin
               n_failed++;
               $display("test %s: failed with %0d errors", name, err_count - grp_start);
            end else begin
               $display("test %s: ok", name);
            end
            grp_start = err_count;
         end
         if (r < rows.size()) begin
            exp_ready = (line_left.size() < IQ_ENTRIES) && !row.redirect;
            check_value(row.name, "ready_o", 32'(exp_ready), 32'(fetch_ready));
            take = line_pending && exp_ready;
            update_ref(row, n, take);
         end
      end

      $display("tests: %0d run, %0d failed, %0d mismatches", n_tests, n_failed, err_count);
      if (err_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin : watchdog
      wait (table_built);
      #((rows.size() + RESET_CYCLES + WD_MARGIN) * CLK_PERIOD);
      $display("timeout: the stimulus table did not finish in the expected time");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- verilog.f
hw/iq_pkg.sv
hw/iq_entry_store.sv
hw/iq_head_ctrl.sv
hw/iq_byte_aligner.sv
hw/instruction_queue.sv
dv/instruction_queue_checker.sv
dv/instruction_queue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the instruction queue testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module instruction_queue_tb \
   -o sim_instruction_queue

./obj_dir/sim_instruction_queue 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
